//--- filelist.f
hdl/env_pkg.sv
hdl/slot_sequencer.sv
hdl/op_reg_file.sv
hdl/rate_counter_ram.sv
hdl/env_rate_counter.sv
hdl/env_state_fsm.sv
hdl/env_attenuation.sv
hdl/env_gen_top.sv
dv/env_gen_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= env_gen_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- dv/env_gen_tb.sv
/*
 * envelope generator testbench
 * LCG driven register writes and sweeps, checked against a per-slot model
 */
`timescale 1ns/1ns

module env_gen_tb
    import env_pkg::*;
();

    localparam int CLK_HALF = 4;
    localparam int SWEEP_TIMEOUT = NUM_SLOTS + 10;
    localparam int MAX_SWEEPS = 400;
    localparam int RANDOM_SWEEPS = 200;
    localparam int TICK_TO_VALID = 3;

    logic clk;
    logic reset;
    logic sample_tick;
    logic nts;
    logic reg_wr;
    reg_addr_t reg_addr;
    reg_byte_u reg_data;
    logic env_valid;
    env_out_t env_out;

    // model of every slot, flat index = bank * 9 + op
    logic [3:0] model_ar [NUM_SLOTS];
    logic [3:0] model_dr [NUM_SLOTS];
    logic [3:0] model_sl [NUM_SLOTS];
    logic [3:0] model_rr [NUM_SLOTS];
    logic model_key_on [NUM_SLOTS];
    logic model_ksr [NUM_SLOTS];
    logic [2:0] model_block [NUM_SLOTS];
    logic [1:0] model_fnum_hi [NUM_SLOTS];
    logic [14:0] model_counter [NUM_SLOTS];
    env_state_e model_state [NUM_SLOTS];
    logic model_key_prev [NUM_SLOTS];
    logic [8:0] model_atten [NUM_SLOTS];
    // last DUT output seen per slot
    env_out_t last_out [NUM_SLOTS];

    int error_count;
    int test_count;
    int test_bad_count;
    int test_start_errors;
    int unsigned lcg_state;

    always #CLK_HALF clk = ~clk;

    env_gen_top DUT (
        .clk(clk),
        .reset(reset),
        .sample_tick(sample_tick),
        .nts(nts),
        .reg_wr(reg_wr),
        .reg_addr(reg_addr),
        .reg_data(reg_data),
        .env_valid(env_valid),
        .env_out(env_out)
    );

    // value in 0 .. range-1
    function automatic int unsigned next_rand(input int unsigned range);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % range;
    endfunction

    function automatic slot_id_t slot_of(input int idx);
        slot_id_t s;
        s.bank_num = BANK_NUM_WIDTH'(idx / NUM_OPS_PER_BANK);
        s.op_num = OP_NUM_WIDTH'(idx % NUM_OPS_PER_BANK);
        return s;
    endfunction

    function automatic env_out_t make_out(input int idx, input env_state_e st, input int atten);
        env_out_t o;
        o.slot = slot_of(idx);
        o.state = st;
        o.atten = 9'(atten);
        return o;
    endfunction

    // byte layout per group, high nibble first
    function automatic void model_write(input reg_group_e group, input int idx,
                                        input logic [7:0] data);
        case (group)
            GRP_AR_DR: begin
                model_ar[idx] = data[7:4];
                model_dr[idx] = data[3:0];
            end
            GRP_SL_RR: begin
                model_sl[idx] = data[7:4];
                model_rr[idx] = data[3:0];
            end
            GRP_KEY_BLK: begin
                model_key_on[idx] = data[7];
                model_ksr[idx] = data[6];
                model_block[idx] = data[5:3];
                model_fnum_hi[idx] = data[2:1];
            end
            default: begin
            end
        endcase
    endfunction

    // one slot visit: rate, counter, level step, then phase step
    function automatic env_out_t model_step(input int idx);
        int req;
        int ks;
        int eff;
        int inc;
        int sum;
        int ovf;
        int atten;
        int sustain;
        env_state_e next;
        env_out_t exp_out;
        case (model_state[idx])
            ENV_ATTACK: req = int'(model_ar[idx]);
            ENV_DECAY: req = int'(model_dr[idx]);
            ENV_SUSTAIN: req = 0;
            default: req = int'(model_rr[idx]);
        endcase
        ks = int'(model_block[idx]) * 2;
        ks = ks + int'(nts ? model_fnum_hi[idx][0] : model_fnum_hi[idx][1]);
        if (!model_ksr[idx]) begin
            ks = ks / 4;
        end
        eff = ks + 4 * req;
        if (eff > EFF_RATE_MAX) begin
            eff = EFF_RATE_MAX;
        end
        inc = (4 + eff % 4) << (eff / 4);
        ovf = 0;
        if (req != 0) begin
            sum = int'(model_counter[idx]) + inc;
            ovf = sum >> RATE_COUNTER_WIDTH;
            model_counter[idx] = 15'(sum);
        end
        atten = int'(model_atten[idx]);
        if (model_state[idx] == ENV_ATTACK) begin
            atten = (atten > 8 * ovf) ? atten - 8 * ovf : 0;
        end else if (model_state[idx] != ENV_SUSTAIN) begin
            atten = (atten + ovf > ATTEN_MAX) ? ATTEN_MAX : atten + ovf;
        end
        sustain = int'(model_sl[idx]) * 32;
        next = model_state[idx];
        if (model_key_on[idx] && !model_key_prev[idx]) begin
            next = ENV_ATTACK;
        end else if (!model_key_on[idx]) begin
            next = ENV_RELEASE;
        end else if (model_state[idx] == ENV_ATTACK && atten == 0) begin
            next = ENV_DECAY;
        end else if (model_state[idx] == ENV_DECAY && atten >= sustain) begin
            next = ENV_SUSTAIN;
        end
        // output shows the phase the step was taken in
        exp_out = make_out(idx, model_state[idx], atten);
        model_state[idx] = next;
        model_key_prev[idx] = model_key_on[idx];
        model_atten[idx] = 9'(atten);
        return exp_out;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_env(input env_out_t got, input env_out_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED t=%0t env_out expected %0d.%0d %s %0d, got %0d.%0d %s %0d",
                     $time, exp.slot.bank_num, exp.slot.op_num, exp.state.name(), exp.atten,
                     got.slot.bank_num, got.slot.op_num, got.state.name(), got.atten);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            error_count++;
            $display("FAILED t=%0t %s expected %0d, got %0d", $time, what, exp, got);
        end
    endtask

    task automatic write_reg(input reg_group_e group, input int idx, input logic [7:0] data);
        reg_addr.group = group;
        reg_addr.slot = slot_of(idx);
        reg_data.raw = data;
        reg_wr = 1'b1;
        step();
        reg_wr = 1'b0;
        model_write(group, idx, data);
    endtask

    // keeps ksr, block and fnum from the model, sets the key bit
    task automatic write_key(input int idx, input logic key);
        write_reg(GRP_KEY_BLK, idx, 8'(int'(key) * 128 + int'(model_ksr[idx]) * 64 +
                  int'(model_block[idx]) * 8 + int'(model_fnum_hi[idx]) * 2));
    endtask

    // one tick, collect all strobes, then a few idle cycles
    task automatic run_sweep();
        int cycles;
        int count;
        int first;
        sample_tick = 1'b1;
        step();
        sample_tick = 1'b0;
        cycles = 1;
        count = 0;
        first = 0;
        while (count < NUM_SLOTS && cycles < SWEEP_TIMEOUT) begin
            if (env_valid) begin
                if (count == 0) begin
                    first = cycles;
                end
                check_env(env_out, model_step(count));
                last_out[count] = env_out;
                count++;
            end
            step();
            cycles++;
        end
        if (count < NUM_SLOTS) begin
            error_count++;
            $display("timeout at t=%0t, sweep gave only %0d of %0d strobes",
                     $time, count, NUM_SLOTS);
        end else begin
            check_count("tick to first env_valid", first, TICK_TO_VALID);
            check_count("env_valid span", cycles - first, NUM_SLOTS);
        end
        // stray strobes after the sweep
        repeat (3) begin
            if (env_valid) begin
                count++;
            end
            step();
        end
        check_count("env_valid strobes", count, NUM_SLOTS);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_start_errors) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_bad_count++;
            $display("test %0d %s: %0d errors", test_count, name,
                     error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    // true while any keyed slot other than the frozen one is short of the goal
    function automatic bit slots_pending(input int goal);
        bit pending;
        pending = 1'b0;
        for (int i = 0; i < NUM_SLOTS - 1; i++) begin
            // freshly keyed slots sit in release until their first sweep
            if (goal == 0 && model_state[i] inside {ENV_ATTACK, ENV_RELEASE}) begin
                pending = 1'b1;
            end
            if (goal == 1 && model_state[i] != ENV_SUSTAIN) begin
                pending = 1'b1;
            end
            if (goal == 2 && model_atten[i] != 9'(ATTEN_MAX)) begin
                pending = 1'b1;
            end
        end
        return pending;
    endfunction

    // sweep until the goal is met, bounded by MAX_SWEEPS
    task automatic sweep_until(input int goal, input string what);
        int sweeps;
        sweeps = 0;
        while (slots_pending(goal) && sweeps < MAX_SWEEPS) begin
            run_sweep();
            sweeps++;
        end
        if (slots_pending(goal)) begin
            error_count++;
            $display("timeout: %s not reached within %0d sweeps", what, MAX_SWEEPS);
        end
    endtask

    initial begin
        int idx;
        int ar;
        clk = 1'b0;
        reset = 1'b1;
        sample_tick = 1'b0;
        nts = 1'b0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        lcg_state = 99;
        error_count = 0;
        test_count = 0;
        test_bad_count = 0;
        test_start_errors = 0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            model_write(GRP_AR_DR, i, 8'h00);
            model_write(GRP_SL_RR, i, 8'h00);
            model_write(GRP_KEY_BLK, i, 8'h00);
            model_counter[i] = '0;
            model_state[i] = ENV_RELEASE;
            model_key_prev[i] = 1'b0;
            model_atten[i] = 9'(ATTEN_MAX);
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        step();

        // idle sweep straight out of reset
        run_sweep();
        for (int i = 0; i < NUM_SLOTS; i++) begin
            check_env(last_out[i], make_out(i, ENV_RELEASE, ATTEN_MAX));
        end
        end_test("reset sweep");

        // all three byte views, last slot keyed with a zero attack rate
        for (int i = 0; i < NUM_SLOTS; i++) begin
            ar = (i == NUM_SLOTS - 1) ? 0 : 13 + int'(next_rand(3));
            write_reg(GRP_AR_DR, i, 8'(ar * 16 + 14 + int'(next_rand(2))));
            write_reg(GRP_SL_RR, i, 8'((1 + int'(next_rand(15))) * 16 + 14 + int'(next_rand(2))));
            write_reg(GRP_KEY_BLK, i, 8'(128 + int'(next_rand(64)) * 2));
        end
        sweep_until(0, "end of attack");
        end_test("attack");

        sweep_until(1, "sustain");
        repeat (3) run_sweep();
        for (int i = 0; i < NUM_SLOTS - 1; i++) begin
            check_env(last_out[i], make_out(i, ENV_SUSTAIN, int'(model_atten[i])));
        end
        check_env(last_out[NUM_SLOTS - 1], make_out(NUM_SLOTS - 1, ENV_ATTACK, ATTEN_MAX));
        end_test("decay and sustain");

        for (int i = 0; i < NUM_SLOTS - 1; i++) begin
            write_key(i, 1'b0);
        end
        sweep_until(2, "release to silence");
        repeat (2) run_sweep();
        for (int i = 0; i < NUM_SLOTS - 1; i++) begin
            check_env(last_out[i], make_out(i, ENV_RELEASE, ATTEN_MAX));
        end
        end_test("release");

        // random settings, split and key toggles between sweeps
        for (int s = 0; s < RANDOM_SWEEPS; s++) begin
            repeat (next_rand(4)) begin
                write_reg(reg_group_e'(2'(next_rand(3))), int'(next_rand(NUM_SLOTS)),
                          8'(next_rand(256)));
            end
            if (next_rand(3) == 0) begin
                idx = int'(next_rand(NUM_SLOTS));
                write_key(idx, !model_key_on[idx]);
            end
            nts = 1'(next_rand(2));
            run_sweep();
        end
        end_test("random sweeps");

        $display("%0d tests run, %0d clean, %0d with errors, %0d check errors",
                 test_count, test_count - test_bad_count, test_bad_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- hdl/env_gen_top.sv
/*
 * envelope generator top
 * sequencer, register file, rate counter, state machine and attenuation
 */
`timescale 1ns/1ns

module env_gen_top
    import env_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic sample_tick,
    input logic nts,
    input logic reg_wr,
    input reg_addr_t reg_addr,
    input reg_byte_u reg_data,
    output logic env_valid,
    output env_out_t env_out
);

    logic slot_en;
    slot_id_t slot;
    op_regs_t regs;
    env_state_e state;
    logic [REG_ENV_WIDTH-1:0] requested_rate;
    logic [OVERFLOW_WIDTH-1:0] overflow;
    logic [ATTEN_WIDTH-1:0] atten_next;

    slot_sequencer sequencer (
        .clk(clk),
        .reset(reset),
        .sample_tick(sample_tick),
        .slot_en(slot_en),
        .slot(slot)
    );

    op_reg_file reg_file (
        .clk(clk),
        .reset(reset),
        .reg_wr(reg_wr),
        .reg_addr(reg_addr),
        .reg_data(reg_data),
        .rd_slot(slot),
        .regs(regs)
    );

    // overflow is ready at p1
    env_rate_counter rate_counter (
        .clk(clk),
        .reset(reset),
        .slot_en(slot_en),
        .slot(slot),
        .nts(nts),
        .regs(regs),
        .requested_rate(requested_rate),
        .overflow(overflow)
    );

    env_state_fsm state_fsm (
        .clk(clk),
        .reset(reset),
        .slot_en(slot_en),
        .slot(slot),
        .regs(regs),
        .atten_next(atten_next),
        .state(state),
        .requested_rate(requested_rate)
    );

    env_attenuation attenuation (
        .clk(clk),
        .reset(reset),
        .slot_en(slot_en),
        .slot(slot),
        .state(state),
        .overflow(overflow),
        .atten_next(atten_next),
        .env_valid(env_valid),
        .env_out(env_out)
    );

endmodule

//--- hdl/env_attenuation.sv
/*
 * envelope attenuation
 * per-slot level store, saturating step and the registered output
 */
`timescale 1ns/1ns

module env_attenuation
    import env_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic slot_en,
    input slot_id_t slot,
    input env_state_e state,
    input logic [OVERFLOW_WIDTH-1:0] overflow,
    output logic [ATTEN_WIDTH-1:0] atten_next,
    output logic env_valid,
    output env_out_t env_out
);

    logic [ATTEN_WIDTH-1:0] atten_mem [NUM_BANKS][NUM_OPS_PER_BANK];
    logic slot_en_p1;
    slot_id_t slot_p1;
    env_state_e state_p1;
    logic [ATTEN_WIDTH-1:0] atten_p1;
    logic [ATTEN_WIDTH:0] rise_p1;
    logic [ATTEN_WIDTH-1:0] drop_p1;

    // registered read, state captured alongside
    always_ff @(posedge clk) begin
        if (slot_en) begin
            atten_p1 <= atten_mem[slot.bank_num][slot.op_num];
        end
        slot_p1 <= slot;
        state_p1 <= state;
    end

    assign rise_p1 = (ATTEN_WIDTH+1)'(atten_p1) + (ATTEN_WIDTH+1)'(overflow);
    // linear attack step, 8 per overflow
    assign drop_p1 = ATTEN_WIDTH'(overflow) << ATTACK_STEP_SHIFT;

    always_comb begin
        case (state_p1)
            ENV_ATTACK: atten_next = (atten_p1 > drop_p1) ? atten_p1 - drop_p1 : '0;
            ENV_SUSTAIN: atten_next = atten_p1;
            default: begin
                // decay and release climb toward silence
                if (rise_p1 > (ATTEN_WIDTH+1)'(ATTEN_MAX)) begin
                    atten_next = ATTEN_WIDTH'(ATTEN_MAX);
                end else begin
                    atten_next = rise_p1[ATTEN_WIDTH-1:0];
                end
            end
        endcase
    end

    // output carries the state the step was taken in
    always_ff @(posedge clk) begin
        env_out.slot <= slot_p1;
        env_out.state <= state_p1;
        env_out.atten <= atten_next;
    end

    // strobes and the store, write lands from the p2 output register
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_en_p1 <= 1'b0;
            env_valid <= 1'b0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < NUM_OPS_PER_BANK; o++) begin
                    atten_mem[b][o] <= ATTEN_WIDTH'(ATTEN_MAX);
                end
            end
        end else begin
            slot_en_p1 <= slot_en;
            env_valid <= slot_en_p1;
            if (env_valid) begin
                atten_mem[env_out.slot.bank_num][env_out.slot.op_num] <= env_out.atten;
            end
        end
    end

    // saturation keeps the step from wrapping past 0 or ATTEN_MAX
    atten_in_range: assert property (@(posedge clk) disable iff (reset)
        slot_en_p1 |-> ((state_p1 == ENV_ATTACK) ? (atten_next <= atten_p1)
                                                 : (atten_next >= atten_p1)));

endmodule

//--- hdl/env_state_fsm.sv
/*
 * envelope state machine
 * per-slot ADSR state and key history, requested rate and transitions
 */
`timescale 1ns/1ns

module env_state_fsm
    import env_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic slot_en,
    input slot_id_t slot,
    input op_regs_t regs,
    input logic [ATTEN_WIDTH-1:0] atten_next,
    output env_state_e state,
    output logic [REG_ENV_WIDTH-1:0] requested_rate
);

    env_state_e state_mem [NUM_BANKS][NUM_OPS_PER_BANK];
    logic key_mem [NUM_BANKS][NUM_OPS_PER_BANK];
    logic slot_en_p1;
    slot_id_t slot_p1;
    env_state_e state_p1;
    env_state_e state_next;
    logic key_on_p1;
    logic key_prev_p1;
    logic [REG_ENV_WIDTH-1:0] sl_p1;
    logic [ATTEN_WIDTH-1:0] sustain_level_p1;

    // stored state of the slot at p0
    assign state = state_mem[slot.bank_num][slot.op_num];

    // rate request follows the current phase
    always_comb begin
        case (state)
            ENV_ATTACK: requested_rate = regs.ar;
            ENV_DECAY: requested_rate = regs.dr;
            ENV_SUSTAIN: requested_rate = '0;
            default: requested_rate = regs.rr;
        endcase
    end

    // p0 values needed by the p1 decision
    always_ff @(posedge clk) begin
        slot_p1 <= slot;
        state_p1 <= state;
        key_on_p1 <= regs.key_on;
        key_prev_p1 <= key_mem[slot.bank_num][slot.op_num];
        sl_p1 <= regs.sl;
    end

    assign sustain_level_p1 = ATTEN_WIDTH'(sl_p1) << SUSTAIN_SHIFT;

    // key events first, then level driven phase changes
    always_comb begin
        state_next = state_p1;
        if (key_on_p1 && !key_prev_p1) begin
            state_next = ENV_ATTACK;
        end else if (!key_on_p1) begin
            state_next = ENV_RELEASE;
        end else begin
            case (state_p1)
                ENV_ATTACK: begin
                    if (atten_next == '0) begin
                        state_next = ENV_DECAY;
                    end
                end
                ENV_DECAY: begin
                    if (atten_next >= sustain_level_p1) begin
                        state_next = ENV_SUSTAIN;
                    end
                end
                default: begin
                    // sustain and release hold until a key event
                end
            endcase
        end
    end

    // write back at the end of p1, slots start silent in release
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_en_p1 <= 1'b0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < NUM_OPS_PER_BANK; o++) begin
                    state_mem[b][o] <= ENV_RELEASE;
                    key_mem[b][o] <= 1'b0;
                end
            end
        end else begin
            slot_en_p1 <= slot_en;
            if (slot_en_p1) begin
                state_mem[slot_p1.bank_num][slot_p1.op_num] <= state_next;
                key_mem[slot_p1.bank_num][slot_p1.op_num] <= key_on_p1;
            end
        end
    end

    sustain_from_decay: assert property (@(posedge clk) disable iff (reset)
        (slot_en_p1 && state_next == ENV_SUSTAIN) |-> state_p1 inside {ENV_DECAY, ENV_SUSTAIN});

endmodule

//--- hdl/env_rate_counter.sv
/*
 * envelope rate counter
 * key scaled effective rate, per-slot counter step and overflow count
 */
`timescale 1ns/1ns

module env_rate_counter
    import env_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic slot_en,
    input slot_id_t slot,
    input logic nts,
    input op_regs_t regs,
    input logic [REG_ENV_WIDTH-1:0] requested_rate,
    output logic [OVERFLOW_WIDTH-1:0] overflow
);

    logic [3:0] ks_full_p0;
    logic [3:0] ks_p0;
    logic [6:0] eff_sum_p0;
    logic [5:0] effective_rate_p1;
    logic [RATE_COUNTER_WIDTH+OVERFLOW_WIDTH-1:0] increment_p1;
    logic [RATE_COUNTER_WIDTH+OVERFLOW_WIDTH-1:0] sum_p1;
    logic [RATE_COUNTER_WIDTH-1:0] counter_p1;
    logic [RATE_COUNTER_WIDTH-1:0] counter_new_p2;
    logic slot_en_p1;
    logic slot_en_p2;
    logic rate_nz_p1;
    logic rate_nz_p2;
    slot_id_t slot_p1;
    slot_id_t slot_p2;

    // key scale from block and the split-selected fnum bit
    assign ks_full_p0 = {regs.block, nts ? regs.fnum_hi[0] : regs.fnum_hi[1]};
    // only the coarse part without ksr
    assign ks_p0 = regs.ksr ? ks_full_p0 : (ks_full_p0 >> 2);
    assign eff_sum_p0 = 7'(ks_p0) + 7'({requested_rate, 2'b00});

    // clamp at the rate ceiling
    always_ff @(posedge clk) begin
        if (eff_sum_p0 > 7'(EFF_RATE_MAX)) begin
            effective_rate_p1 <= 6'(EFF_RATE_MAX);
        end else begin
            effective_rate_p1 <= eff_sum_p0[5:0];
        end
    end

    // strobe pipe
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_en_p1 <= 1'b0;
            slot_en_p2 <= 1'b0;
        end else begin
            slot_en_p1 <= slot_en;
            slot_en_p2 <= slot_en_p1;
        end
    end

    // slot and rate flag follow the strobe
    always_ff @(posedge clk) begin
        slot_p1 <= slot;
        slot_p2 <= slot_p1;
        rate_nz_p1 <= (requested_rate != '0);
        rate_nz_p2 <= rate_nz_p1;
    end

    rate_counter_ram counter_ram (
        .clk(clk),
        .reset(reset),
        .rd_en(slot_en),
        .rd_slot(slot),
        .rd_data(counter_p1),
        .wr_en(slot_en_p2 && rate_nz_p2),
        .wr_slot(slot_p2),
        .wr_data(counter_new_p2)
    );

    // step is (4 | low bits) scaled by eff / 4
    assign increment_p1 = (RATE_COUNTER_WIDTH+OVERFLOW_WIDTH)'({1'b1, effective_rate_p1[1:0]})
                          << effective_rate_p1[5:2];
    assign sum_p1 = (RATE_COUNTER_WIDTH+OVERFLOW_WIDTH)'(counter_p1) + increment_p1;

    // zero rate freezes the envelope
    assign overflow = rate_nz_p1 ? sum_p1[RATE_COUNTER_WIDTH +: OVERFLOW_WIDTH] : '0;

    always_ff @(posedge clk) begin
        counter_new_p2 <= sum_p1[RATE_COUNTER_WIDTH-1:0];
    end

    // no step may exceed the one taken at the rate ceiling
    eff_rate_ceiling: assert property (@(posedge clk) disable iff (reset)
        slot_en_p1 |-> increment_p1 <=
            ((RATE_COUNTER_WIDTH+OVERFLOW_WIDTH)'({1'b1, 2'(EFF_RATE_MAX % 4)})
             << (EFF_RATE_MAX / 4)));

endmodule

//--- hdl/rate_counter_ram.sv
/*
 * rate counter store
 * one 15-bit counter per slot, registered read, separate write port
 */
`timescale 1ns/1ns

module rate_counter_ram
    import env_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic rd_en,
    input slot_id_t rd_slot,
    output logic [RATE_COUNTER_WIDTH-1:0] rd_data,
    input logic wr_en,
    input slot_id_t wr_slot,
    input logic [RATE_COUNTER_WIDTH-1:0] wr_data
);

    logic [RATE_COUNTER_WIDTH-1:0] counter_mem [NUM_BANKS][NUM_OPS_PER_BANK];

    // write port, counters start from zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < NUM_OPS_PER_BANK; o++) begin
                    counter_mem[b][o] <= '0;
                end
            end
        end else if (wr_en) begin
            counter_mem[wr_slot.bank_num][wr_slot.op_num] <= wr_data;
        end
    end

    // read lands one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= counter_mem[rd_slot.bank_num][rd_slot.op_num];
        end
    end

endmodule

//--- hdl/op_reg_file.sv
/*
 * operator register file
 * per-slot envelope settings, written one byte view at a time
 */
`timescale 1ns/1ns

module op_reg_file
    import env_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic reg_wr,
    input reg_addr_t reg_addr,
    input reg_byte_u reg_data,
    input slot_id_t rd_slot,
    output op_regs_t regs
);

    op_regs_t regs_mem [NUM_BANKS][NUM_OPS_PER_BANK];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < NUM_OPS_PER_BANK; o++) begin
                    regs_mem[b][o] <= '0;
                end
            end
        end else if (reg_wr) begin
            // group picks which union view is decoded
            case (reg_addr.group)
                GRP_AR_DR: begin
                    regs_mem[reg_addr.slot.bank_num][reg_addr.slot.op_num].ar <= reg_data.ar_dr.ar;
                    regs_mem[reg_addr.slot.bank_num][reg_addr.slot.op_num].dr <= reg_data.ar_dr.dr;
                end
                GRP_SL_RR: begin
                    regs_mem[reg_addr.slot.bank_num][reg_addr.slot.op_num].sl <= reg_data.sl_rr.sl;
                    regs_mem[reg_addr.slot.bank_num][reg_addr.slot.op_num].rr <= reg_data.sl_rr.rr;
                end
                GRP_KEY_BLK: begin
                    regs_mem[reg_addr.slot.bank_num][reg_addr.slot.op_num].key_on <=
                        reg_data.key_blk.key_on;
                    regs_mem[reg_addr.slot.bank_num][reg_addr.slot.op_num].ksr <=
                        reg_data.key_blk.ksr;
                    regs_mem[reg_addr.slot.bank_num][reg_addr.slot.op_num].block <=
                        reg_data.key_blk.block;
                    regs_mem[reg_addr.slot.bank_num][reg_addr.slot.op_num].fnum_hi <=
                        reg_data.key_blk.fnum_hi;
                end
                default: begin
                    // unused group, write dropped
                end
            endcase
        end
    end

    // combinational read for the slot at p0
    assign regs = regs_mem[rd_slot.bank_num][rd_slot.op_num];

endmodule

//--- hdl/slot_sequencer.sv
/*
 * slot sequencer
 * turns one sample tick into a sweep of 18 slot strobes, bank 0 first
 */
`timescale 1ns/1ns

module slot_sequencer
    import env_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic sample_tick,
    output logic slot_en,
    output slot_id_t slot
);

    logic last_slot;
    logic [1:0] drain;
    logic busy;

    // final slot of the sweep
    assign last_slot = (slot.bank_num == BANK_NUM_WIDTH'(NUM_BANKS - 1)) &&
                       (slot.op_num == OP_NUM_WIDTH'(NUM_OPS_PER_BANK - 1));

    // sweep counts as busy until the last slot leaves p2
    assign busy = slot_en || (|drain);

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_en <= 1'b0;
            slot <= '0;
            drain <= '0;
        end else begin
            drain <= {drain[0], slot_en && last_slot};
            if (sample_tick) begin
                slot_en <= 1'b1;
                slot <= '0;
            end else if (slot_en) begin
                if (last_slot) begin
                    slot_en <= 1'b0;
                    slot <= '0;
                end else if (slot.op_num == OP_NUM_WIDTH'(NUM_OPS_PER_BANK - 1)) begin
                    // wrap into next bank
                    slot.op_num <= '0;
                    slot.bank_num <= slot.bank_num + 1'b1;
                end else begin
                    slot.op_num <= slot.op_num + 1'b1;
                end
            end
        end
    end

    // ticks must be spaced past the pipeline drain
    tick_spacing: assert property (@(posedge clk) disable iff (reset)
        sample_tick |-> !busy);

endmodule

//--- hdl/env_pkg.sv
/*
 * envelope generator shared definitions
 * slot geometry, field widths, envelope states and register layouts
 */
package env_pkg;

    // slot geometry
    localparam NUM_BANKS = 2;
    localparam NUM_OPS_PER_BANK = 9;
    localparam NUM_SLOTS = NUM_BANKS * NUM_OPS_PER_BANK;
    localparam BANK_NUM_WIDTH = 1;
    localparam OP_NUM_WIDTH = 4;

    // register fields and envelope arithmetic
    localparam REG_ENV_WIDTH = 4;
    localparam RATE_COUNTER_WIDTH = 15;
    localparam OVERFLOW_WIDTH = 3;
    localparam EFF_RATE_MAX = 60;
    localparam ATTEN_WIDTH = 9;
    localparam ATTEN_MAX = 511;
    localparam SUSTAIN_SHIFT = 5;
    localparam ATTACK_STEP_SHIFT = 3;

    typedef enum logic [1:0] {
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_e;

    // which field group a register write lands in
    typedef enum logic [1:0] {
        GRP_AR_DR,
        GRP_SL_RR,
        GRP_KEY_BLK
    } reg_group_e;

    typedef struct packed {
        logic [BANK_NUM_WIDTH-1:0] bank_num;
        logic [OP_NUM_WIDTH-1:0] op_num;
    } slot_id_t;

    typedef struct packed {
        reg_group_e group;
        slot_id_t slot;
    } reg_addr_t;

    typedef struct packed {
        logic [REG_ENV_WIDTH-1:0] ar;
        logic [REG_ENV_WIDTH-1:0] dr;
    } ar_dr_view_t;

    typedef struct packed {
        logic [REG_ENV_WIDTH-1:0] sl;
        logic [REG_ENV_WIDTH-1:0] rr;
    } sl_rr_view_t;

    // fnum_hi holds the two top fnum bits only
    typedef struct packed {
        logic key_on;
        logic ksr;
        logic [2:0] block;
        logic [1:0] fnum_hi;
        logic spare;
    } key_blk_view_t;

    // one write byte, meaning picked by the address group
    typedef union packed {
        logic [7:0] raw;
        ar_dr_view_t ar_dr;
        sl_rr_view_t sl_rr;
        key_blk_view_t key_blk;
    } reg_byte_u;

    typedef struct packed {
        logic [REG_ENV_WIDTH-1:0] ar;
        logic [REG_ENV_WIDTH-1:0] dr;
        logic [REG_ENV_WIDTH-1:0] sl;
        logic [REG_ENV_WIDTH-1:0] rr;
        logic key_on;
        logic ksr;
        logic [2:0] block;
        logic [1:0] fnum_hi;
    } op_regs_t;

    typedef struct packed {
        slot_id_t slot;
        env_state_e state;
        logic [ATTEN_WIDTH-1:0] atten;
    } env_out_t;

endpackage
